/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int N_WAYS  = 2,
    parameter int N_LINES = 8
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              p_strobe_i,
    input  logic              p_rw_i,
    input  logic              m_ready_i,
    input  line_t             m_data_i,
    dcache_lookup_if.ctrl     lk,
    input  line_t             victim_line_i,  // Data RAM output of the victim way
    output logic [N_WAYS-1:0] way_we_o,
    output logic              m_strobe_o,
    output logic              m_rw_o,
    output addr_t             m_addr_o,
    output line_t             m_data_o,
    output logic              p_ready_o,
    output line_t             mem_line_o,     // Refill data
    output ctrl_state_t       state_o
);

    localparam int SET_W = $clog2(N_LINES);
    localparam int TAG_W = XLEN - SET_W - WORD_BITS - BYTE_BITS;
    localparam int OFF_W = WORD_BITS + BYTE_BITS;

    ctrl_state_t      state_q;
    ctrl_state_t      state_d;
    logic             rw_q;        // 1 for a store
    logic             req_start;   // Memory request issued this cycle
    logic             wb_start;    // That request is a write-back
    logic [TAG_W-1:0] line_tag;
    logic [SET_W-1:0] line_set;
    addr_t            line_addr;

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= IDLE;
            rw_q    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == IDLE && p_strobe_i)
            begin
                rw_q <= p_rw_i;
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (p_strobe_i)
                    state_d = LOOKUP;
            LOOKUP:
                if (lk.hit)
                    state_d = IDLE;          // Hit done in one cycle
                else if (lk.victim_dirty)
                    state_d = WB_REQ;
                else
                    state_d = RD_REQ;
            WB_REQ:
                if (m_ready_i)
                    state_d = WB_DONE;
            WB_DONE:
                state_d = RD_REQ;
            RD_REQ:
                if (m_ready_i)
                    state_d = RD_DONE;
            RD_DONE:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    // Memory request setup
    assign req_start = (state_q == LOOKUP && !lk.hit) || state_q == WB_DONE;
    assign wb_start  = state_q == LOOKUP && lk.victim_dirty;
    assign line_tag  = wb_start ? lk.victim_tag : lk.req_tag;  // Victim or missing line
    assign line_set  = lk.set_idx;
    assign line_addr = {line_tag, line_set, {OFF_W{1'b0}}};   // Line aligned

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else if (req_start)
        begin
            m_strobe_o <= 1'b1;
            m_rw_o     <= wb_start;
        end
        else if (m_ready_i)
        begin
            m_strobe_o <= 1'b0;  // Low the cycle after the ack
        end
    end

    // Request payload and refill capture
    always_ff @(posedge clk_i)
    begin
        if (req_start)
        begin
            m_addr_o <= line_addr;
            m_data_o <= victim_line_i;
        end
        if (state_q == RD_REQ && m_ready_i)
        begin
            mem_line_o <= m_data_i;
        end
    end

    // ========================================
    // RAM write enables and handshakes
    // ========================================
    always_comb
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_we_o[w] = (state_q == LOOKUP && lk.hit && rw_q && lk.hit_way == w)
                        || (state_q == RD_DONE && lk.victim_way == w);
        end
    end

    assign lk.fill_en      = state_q == RD_DONE;
    assign lk.store_hit_en = rw_q && ((state_q == LOOKUP && lk.hit) || state_q == RD_DONE);
    assign p_ready_o       = (state_q == LOOKUP && lk.hit) || state_q == RD_DONE;
    assign state_o         = state_q;

endmodule

/* dcache_lookup_if.sv */
`timescale 1ns/1ps

interface dcache_lookup_if import dcache_pkg::*; #(
    parameter int N_WAYS  = 2,
    parameter int N_LINES = 8
);

    localparam int WAY_W = (N_WAYS > 1) ? $clog2(N_WAYS) : 1;
    localparam int SET_W = $clog2(N_LINES);
    localparam int TAG_W = XLEN - SET_W - WORD_BITS - BYTE_BITS;

    // From the tag lookup
    logic                 hit;
    logic [WAY_W-1:0]     hit_way;
    logic [WAY_W-1:0]     victim_way;    // FIFO head of the set
    logic                 victim_dirty;  // Victim valid and dirty
    logic [TAG_W-1:0]     victim_tag;
    logic [SET_W-1:0]     set_idx;       // Also the RAM address
    logic [WORD_BITS-1:0] word_off;
    logic [TAG_W-1:0]     req_tag;

    // From the controller
    logic                 fill_en;       // Victim refilled this cycle
    logic                 store_hit_en;  // Line being written gets dirty

    modport lookup (
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        output set_idx, word_off, req_tag,
        input  fill_en, store_hit_en
    );

    modport ctrl (
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, set_idx, req_tag,
        output fill_en, store_hit_en
    );

    modport datapath (
        input  hit, word_off, store_hit_en
    );

endinterface

/* dcache_pkg.sv */
package dcache_pkg;

    // ========================================
    // Core word and line geometry
    // ========================================
    localparam int XLEN           = 32;                    // Processor word width
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE; // 128 bits per line

    // Low address fields
    localparam int BYTE_BITS = 2;                          // Byte within word
    localparam int WORD_BITS = 2;                          // Word within line

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [XLEN-1:0]     addr_t;                   // Byte address
    typedef logic [XLEN/8-1:0]   be_t;                     // One bit per byte lane

    // Word 0 sits in the top 32 bits, word 3 in the bottom
    typedef logic [LINE_W-1:0]   line_t;

    // ========================================
    // Controller states
    // ========================================
    typedef enum logic [2:0] {
        IDLE    = 3'd0,  // Waiting for a strobe
        LOOKUP  = 3'd1,  // Tag compare, hit finishes here
        WB_REQ  = 3'd2,  // Dirty victim out to memory
        WB_DONE = 3'd3,  // Write-back acked
        RD_REQ  = 3'd4,  // Refill line requested
        RD_DONE = 3'd5   // Refill written, request answered
    } ctrl_state_t;

endpackage

/* dcache_sram.sv */
`timescale 1ns/1ps

module dcache_sram #(
    parameter type PAYLOAD_T = logic [31:0],   // Tag vector or whole line
    parameter int  DEPTH     = 8
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  PAYLOAD_T                 data_i,
    output PAYLOAD_T                 data_o
);

    PAYLOAD_T mem [DEPTH];  // Storage array

    // Read-first, old contents seen on a write cycle
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[addr_i] <= data_i;
        end
        data_o <= mem[addr_i];  // Registered read
    end

endmodule

/* dcache_stim.txt */
# op addr be data rdata hit, all hex, set index is addr[6:4]
# rdata is the expected p_data_o with p_ready_o, zero for stores
R 00000014 0 00000000 a5a50014 0
R 00000018 0 00000000 a5a50018 1
W 00000018 3 11223344 00000000 1
R 00000018 0 00000000 a5a53344 1
W 00000094 c deadbeef 00000000 0
R 00000094 0 00000000 dead0094 1
R 00000010 0 00000000 a5a50010 1
R 00000118 0 00000000 a5a50118 0
R 0000009c 0 00000000 a5a5009c 1
R 00000018 0 00000000 a5a53344 0
R 00000010 0 00000000 a5a50010 1
W 00000204 1 000000ab 00000000 0
R 00000204 0 00000000 a5a502ab 1
W 00000118 f cafef00d 00000000 1
R 00000118 0 00000000 cafef00d 1
R 00000190 0 00000000 a5a50190 0
R 00000118 0 00000000 cafef00d 0

/* dcache_tag_lookup.sv */
`timescale 1ns/1ps

module dcache_tag_lookup import dcache_pkg::*; #(
    parameter int N_WAYS  = 2,
    parameter int N_LINES = 8,
    localparam int WAY_W  = (N_WAYS > 1) ? $clog2(N_WAYS) : 1,
    localparam int SET_W  = $clog2(N_LINES),
    localparam int TAG_W  = XLEN - SET_W - WORD_BITS - BYTE_BITS
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         p_strobe_i,
    input  addr_t                        p_addr_i,
    input  logic [N_WAYS-1:0][TAG_W-1:0] tags_i,   // One tag per way
    dcache_lookup_if.lookup              lk
);

    localparam int OFF_W = WORD_BITS + BYTE_BITS;  // Bits below the set index

    addr_t             addr_q;               // Request address
    logic [N_WAYS-1:0] valid_q [N_LINES];
    logic [N_WAYS-1:0] dirty_q [N_LINES];
    logic [WAY_W-1:0]  fifo_q  [N_LINES];    // Next way to replace, per set
    logic [N_WAYS-1:0] way_match;

    // Strobe only comes in IDLE, so it picks the live address
    always_ff @(posedge clk_i)
    begin
        if (p_strobe_i)
        begin
            addr_q <= p_addr_i;
        end
    end

    // Address split
    assign lk.set_idx  = p_strobe_i ? p_addr_i[OFF_W +: SET_W] : addr_q[OFF_W +: SET_W];
    assign lk.word_off = addr_q[BYTE_BITS +: WORD_BITS];
    assign lk.req_tag  = addr_q[XLEN-1 -: TAG_W];

    // ========================================
    // Tag compare across all ways
    // ========================================
    always_comb
    begin
        lk.hit_way = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_match[w] = valid_q[lk.set_idx][w] && (tags_i[w] == lk.req_tag);
        end
        for (int w = N_WAYS - 1; w >= 0; w--)
        begin
            if (way_match[w])
            begin
                lk.hit_way = WAY_W'(w);  // Lowest matching way wins
            end
        end
    end

    assign lk.hit          = |way_match;
    assign lk.victim_way   = fifo_q[lk.set_idx];
    assign lk.victim_tag   = tags_i[lk.victim_way];
    assign lk.victim_dirty = valid_q[lk.set_idx][lk.victim_way]
                           && dirty_q[lk.set_idx][lk.victim_way];

    // Valid, dirty and FIFO state
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_LINES; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end
        else if (lk.fill_en)
        begin
            valid_q[lk.set_idx][lk.victim_way] <= 1'b1;
            dirty_q[lk.set_idx][lk.victim_way] <= lk.store_hit_en;  // Store miss lands dirty
            fifo_q[lk.set_idx] <= (lk.victim_way == WAY_W'(N_WAYS - 1)) ? '0
                                : lk.victim_way + 1'b1;             // Wrap to way 0
        end
        else if (lk.store_hit_en)
        begin
            dirty_q[lk.set_idx][lk.hit_way] <= 1'b1;
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int N_WAYS  = 2,
    parameter int N_LINES = 8
) (
    input  logic  clk_i,
    input  logic  rst_i,
    // Processor side
    input  logic  p_strobe_i,
    input  logic  p_rw_i,      // 1 for store
    input  be_t   p_be_i,
    input  addr_t p_addr_i,
    input  word_t p_data_i,
    output word_t p_data_o,
    output logic  p_ready_o,
    // Memory side
    output logic  m_strobe_o,
    output logic  m_rw_o,      // 1 for write-back
    output addr_t m_addr_o,
    output line_t m_data_o,
    input  logic  m_ready_i,
    input  line_t m_data_i
);

    localparam int SET_W = $clog2(N_LINES);
    localparam int TAG_W = XLEN - SET_W - WORD_BITS - BYTE_BITS;

    logic [N_WAYS-1:0][TAG_W-1:0]  tag_rd;   // Tag RAM outputs
    logic [N_WAYS-1:0][LINE_W-1:0] line_rd;  // Data RAM outputs
    logic [N_WAYS-1:0]             way_we;
    ctrl_state_t                   state;
    line_t                         mem_line;
    line_t                         wr_line;
    line_t                         hit_line;
    line_t                         victim_line;

    dcache_lookup_if #(.N_WAYS(N_WAYS), .N_LINES(N_LINES)) lk ();

    assign hit_line    = line_rd[lk.hit_way];
    assign victim_line = line_rd[lk.victim_way];

    // ========================================
    // Stages
    // ========================================
    dcache_tag_lookup #(.N_WAYS(N_WAYS), .N_LINES(N_LINES)) u_lookup (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_addr_i   (p_addr_i),
        .tags_i     (tag_rd),
        .lk         (lk.lookup)
    );

    dcache_ctrl #(.N_WAYS(N_WAYS), .N_LINES(N_LINES)) u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .p_strobe_i    (p_strobe_i),
        .p_rw_i        (p_rw_i),
        .m_ready_i     (m_ready_i),
        .m_data_i      (m_data_i),
        .lk            (lk.ctrl),
        .victim_line_i (victim_line),
        .way_we_o      (way_we),
        .m_strobe_o    (m_strobe_o),
        .m_rw_o        (m_rw_o),
        .m_addr_o      (m_addr_o),
        .m_data_o      (m_data_o),
        .p_ready_o     (p_ready_o),
        .mem_line_o    (mem_line),
        .state_o       (state)
    );

    dcache_word_merge u_merge (
        .clk_i      (clk_i),
        .p_be_i     (p_be_i),
        .p_data_i   (p_data_i),
        .state_i    (state),
        .hit_line_i (hit_line),
        .mem_line_i (mem_line),
        .lk         (lk.datapath),
        .p_data_o   (p_data_o),
        .wr_line_o  (wr_line)
    );

    // Tag and data RAM pair per way
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        dcache_sram #(.PAYLOAD_T(logic [TAG_W-1:0]), .DEPTH(N_LINES)) u_tag_ram (
            .clk_i  (clk_i),
            .we_i   (way_we[w]),
            .addr_i (lk.set_idx),
            .data_i (lk.req_tag),   // Same tag on store hit and refill
            .data_o (tag_rd[w])
        );

        dcache_sram #(.PAYLOAD_T(line_t), .DEPTH(N_LINES)) u_line_ram (
            .clk_i  (clk_i),
            .we_i   (way_we[w]),
            .addr_i (lk.set_idx),
            .data_i (wr_line),
            .data_o (line_rd[w])
        );
    end

endmodule

/* dcache_word_merge.sv */
`timescale 1ns/1ps

module dcache_word_merge import dcache_pkg::*; (
    input  logic              clk_i,
    input  be_t               p_be_i,
    input  word_t             p_data_i,
    input  ctrl_state_t       state_i,
    input  line_t             hit_line_i,    // Data RAM output of the hit way
    input  line_t             mem_line_i,    // Refill line
    dcache_lookup_if.datapath lk,
    output word_t             p_data_o,
    output line_t             wr_line_o      // Line written into the data RAM
);

    word_t                     store_q;
    be_t                       be_q;
    line_t                     src_line;
    word_t                     old_word;
    word_t                     new_word;
    logic [$clog2(LINE_W)-1:0] word_base;
    logic                      rd_out;

    // Held through the request, loaded while idle
    always_ff @(posedge clk_i)
    begin
        if (state_i == IDLE)
        begin
            store_q <= p_data_i;
            be_q    <= p_be_i;
        end
    end

    // Word 0 at the top of the line
    assign word_base = ($clog2(LINE_W))'((WORDS_PER_LINE - 1 - int'(lk.word_off)) * XLEN);

    always_comb
    begin
        src_line = (state_i == RD_DONE) ? mem_line_i : hit_line_i;
        old_word = src_line[word_base +: XLEN];
        for (int b = 0; b < XLEN / 8; b++)
        begin
            new_word[8*b +: 8] = be_q[b] ? store_q[8*b +: 8] : old_word[8*b +: 8];  // Byte lane
        end
        wr_line_o = src_line;  // Plain refill for a load
        if (lk.store_hit_en)
        begin
            wr_line_o[word_base +: XLEN] = new_word;
        end
    end

    // Loads only, zero otherwise
    assign rd_out   = ((state_i == LOOKUP && lk.hit) || state_i == RD_DONE) && !lk.store_hit_en;
    assign p_data_o = rd_out ? old_word : '0;

endmodule

/* flist.f */
dcache_pkg.sv
dcache_sram.sv
dcache_lookup_if.sv
dcache_tag_lookup.sv
dcache_ctrl.sv
dcache_word_merge.sv
dcache_top.sv
tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dcache -f flist.f -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int N_WAYS  = 2;
    localparam int N_LINES = 8;

    logic  clk_i;
    logic  rst_i;
    logic  p_strobe_i;
    logic  p_rw_i;
    be_t   p_be_i;
    addr_t p_addr_i;
    word_t p_data_i;
    word_t p_data_o;
    logic  p_ready_o;
    logic  m_strobe_o;
    logic  m_rw_o;
    addr_t m_addr_o;
    line_t m_data_o;
    logic  m_ready_i;
    line_t m_data_i;

    int    seed        = 11;
    int    cycle_cnt   = 0;
    int    cycle_limit = 0;             // Armed once the stimulus is read

    // Stimulus columns
    logic  op_rw_q   [$];
    addr_t op_addr_q [$];
    be_t   op_be_q   [$];
    word_t op_data_q [$];
    word_t op_exp_q  [$];
    logic  op_hit_q  [$];

    // Memory traffic seen during one request
    logic  mem_rw_q   [$];
    addr_t mem_addr_q [$];
    line_t mem_line_q [$];

    line_t      mem_lines  [addr_t];    // Lines written back so far
    logic [7:0] shadow_mem [addr_t];    // Bytes stored so far by the processor

    // FIFO cache model per set and way
    addr_t res_line  [N_LINES][N_WAYS];
    logic  res_valid [N_LINES][N_WAYS];
    logic  res_dirty [N_LINES][N_WAYS];
    int    res_ptr   [N_LINES];

    dcache_top #(.N_WAYS(N_WAYS), .N_LINES(N_LINES)) dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_rw_i     (p_rw_i),
        .p_be_i     (p_be_i),
        .p_addr_i   (p_addr_i),
        .p_data_i   (p_data_i),
        .p_data_o   (p_data_o),
        .p_ready_o  (p_ready_o),
        .m_strobe_o (m_strobe_o),
        .m_rw_o     (m_rw_o),
        .m_addr_o   (m_addr_o),
        .m_data_o   (m_data_o),
        .m_ready_i  (m_ready_i),
        .m_data_i   (m_data_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;  // 10 ns period
    end

    // ========================================
    // Error reporting and compare tasks
    // ========================================
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Memory line at la before any write-back
    function automatic line_t initial_line(input addr_t la);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            l[(WORDS_PER_LINE-1-i)*XLEN +: XLEN] = (la + addr_t'(4*i)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    function automatic logic [7:0] shadow_byte(input addr_t a);
        word_t w;
        if (shadow_mem.exists(a))
        begin
            return shadow_mem[a];
        end
        w = {a[31:2], 2'b00} ^ 32'hA5A5_0000;
        return w[8*a[1:0] +: 8];               // Lane b holds byte address +b
    endfunction

    function automatic line_t shadow_line(input addr_t la);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++)
        begin
            for (int b = 0; b < XLEN / 8; b++)
            begin
                l[(WORDS_PER_LINE-1-i)*XLEN + 8*b +: 8] = shadow_byte(la + addr_t'(4*i + b));
            end
        end
        return l;
    endfunction

    // ========================================
    // Memory model with 1 to 4 cycles per access
    // ========================================
    initial
    begin : memory_model
        int wait_cyc;
        m_ready_i = 1'b0;
        m_data_i  = '0;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe_o === 1'b1 && rst_i === 1'b0)
            begin
                mem_rw_q.push_back(m_rw_o);
                mem_addr_q.push_back(m_addr_o);
                mem_line_q.push_back(m_data_o);
                wait_cyc = 1 + ({$random(seed)} % 4);
                repeat (wait_cyc) @(negedge clk_i);
                if (m_addr_o !== mem_addr_q[$] || m_rw_o !== mem_rw_q[$])
                begin
                    stop_with_error("Memory request changed while m_strobe_o was high");
                end
                if (m_rw_o)
                begin
                    mem_lines[m_addr_o] = m_data_o;           // Write-back lands
                end
                else
                begin
                    m_data_i = mem_lines.exists(m_addr_o) ? mem_lines[m_addr_o]
                             : initial_line(m_addr_o);
                end
                m_ready_i = 1'b1;
                @(negedge clk_i);
                m_ready_i = 1'b0;                             // One-cycle ack
            end
        end
    end

    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            stop_with_error($sformatf("Timeout, run passed %0d cycles", cycle_limit));
        end
    end

    task automatic read_stim();
        int          fd;
        int          n;
        logic [7:0]  tok;
        logic [1279:0] skip_line;
        addr_t       addr;
        be_t         be;
        word_t       data;
        word_t       exp;
        logic        hit;
        fd = $fopen("dcache_stim.txt", "r");
        if (fd == 0)
        begin
            stop_with_error("Could not open dcache_stim.txt");
        end
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1)
            begin
                break;
            end
            if (tok == "#")
            begin
                n = $fgets(skip_line, fd);                    // Column notes
            end
            else
            begin
                n = $fscanf(fd, "%h %h %h %h %h", addr, be, data, exp, hit);
                if (n != 5 || (tok != "R" && tok != "W"))
                begin
                    stop_with_error("Malformed line in dcache_stim.txt");
                end
                op_rw_q.push_back(tok == "W");
                op_addr_q.push_back(addr);
                op_be_q.push_back(be);
                op_data_q.push_back(data);
                op_exp_q.push_back(exp);
                op_hit_q.push_back(hit);
            end
        end
        $fclose(fd);
    endtask

    // ========================================
    // One processor request checked end to end
    // ========================================
    task automatic run_op(input logic rw, input addr_t addr, input be_t be,
                          input word_t data, input word_t exp_word, input logic exp_hit);
        int    s;
        int    hit_way;
        int    victim;
        int    lat;
        int    n_exp;
        logic  got_ready;
        word_t got_word;
        addr_t la;
        la      = {addr[31:4], 4'h0};
        s       = int'((addr >> 4) % N_LINES);
        hit_way = -1;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (res_valid[s][w] && res_line[s][w] == la)
            begin
                hit_way = w;
            end
        end
        victim = res_ptr[s];
        mem_rw_q.delete();
        mem_addr_q.delete();
        mem_line_q.delete();

        @(negedge clk_i);                                     // Cache idle here
        p_strobe_i = 1'b1;
        p_rw_i     = rw;
        p_be_i     = be;
        p_addr_i   = addr;
        p_data_i   = data;
        lat        = 0;
        got_ready  = 1'b0;
        got_word   = '0;
        while (!got_ready)
        begin
            @(negedge clk_i);
            lat++;
            got_ready  = (p_ready_o === 1'b1);
            got_word   = p_data_o;
            p_strobe_i = 1'b0;
        end

        check_word("p_data_o", got_word, exp_word);           // Zero for stores
        check_flag("hit", mem_addr_q.size() == 0, exp_hit);
        if ((hit_way >= 0) != exp_hit)
        begin
            stop_with_error("Hit flag in stimulus disagrees with the FIFO cache model");
        end
        if (exp_hit)
        begin
            check_flag("p_ready_o one cycle after strobe", lat == 1, 1'b1);
            if (rw)
            begin
                res_dirty[s][hit_way] = 1'b1;
            end
        end
        else
        begin
            n_exp = (res_valid[s][victim] && res_dirty[s][victim]) ? 2 : 1;
            if (mem_addr_q.size() != n_exp)
            begin
                stop_with_error($sformatf("Miss at %h made %0d memory accesses instead of %0d",
                                          addr, mem_addr_q.size(), n_exp));
            end
            if (n_exp == 2)
            begin
                check_flag("write-back m_rw_o", mem_rw_q[0], 1'b1);
                check_addr("write-back m_addr_o", mem_addr_q[0], res_line[s][victim]);
                check_line("write-back m_data_o", mem_line_q[0],
                           shadow_line(res_line[s][victim]));
            end
            check_flag("refill m_rw_o", mem_rw_q[n_exp-1], 1'b0);
            check_addr("refill m_addr_o", mem_addr_q[n_exp-1], la);   // Line aligned
            res_line[s][victim]  = la;
            res_valid[s][victim] = 1'b1;
            res_dirty[s][victim] = rw;
            res_ptr[s]           = (victim + 1) % N_WAYS;
        end

        if (rw)
        begin
            for (int b = 0; b < XLEN / 8; b++)
            begin
                if (be[b])
                begin
                    shadow_mem[{addr[31:2], 2'b00} + addr_t'(b)] = data[8*b +: 8];
                end
            end
        end
    endtask

    initial
    begin
        rst_i      = 1'b1;
        p_strobe_i = 1'b0;
        p_rw_i     = 1'b0;
        p_be_i     = '0;
        p_addr_i   = '0;
        p_data_i   = '0;
        for (int s = 0; s < N_LINES; s++)
        begin
            res_ptr[s] = 0;
            for (int w = 0; w < N_WAYS; w++)
            begin
                res_line[s][w]  = '0;
                res_valid[s][w] = 1'b0;
                res_dirty[s][w] = 1'b0;
            end
        end
        read_stim();
        cycle_limit = 200 * op_addr_q.size();

        repeat (8) @(negedge clk_i);                          // 8 reset cycles
        check_flag("p_ready_o after reset", p_ready_o, 1'b0);
        check_flag("m_strobe_o after reset", m_strobe_o, 1'b0);
        rst_i = 1'b0;

        for (int i = 0; i < op_addr_q.size(); i++)
        begin
            run_op(op_rw_q[i], op_addr_q[i], op_be_q[i], op_data_q[i], op_exp_q[i], op_hit_q[i]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule
